/* Makefile */
# Verilator build for the ALU peripheral and its testbench

VERILATOR ?= verilator
TOP       ?= alu_unit_tb
SEED      ?= 1
LOG       ?= sim.log
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir

VFLAGS = --timing -f $(FLIST) --top-module $(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS)

$(BUILD_DIR)/V$(TOP): $(FLIST)
	$(VERILATOR) --binary $(VFLAGS) --x-assign unique --x-initial unique \
		--Mdir $(BUILD_DIR) -o V$(TOP)

# the run passes only if the log holds the pass line
sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) +verilator+seed+$(SEED) 2>&1 | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

.PHONY: $(BUILD_DIR)/V$(TOP)

/* dv/alu_unit_asserts.sv */
`timescale 1ns/1ps

module alu_unit_asserts (
    input logic               clk,
    input logic               arst_n,
    input logic               wb_cyc,
    input logic               wb_stb,
    input logic               wb_ack,
    input alu_pkg::alu_data_t wb_dat_r
);

    // count of failed assertions over the whole run
    int violations = 0;

    // ack only answers a live strobe inside a cycle
    ack_needs_strobe: assert property (
        @(posedge clk) disable iff (!arst_n)
        wb_ack |-> (wb_cyc && wb_stb)
    ) else begin
        $error("wb_ack high without wb_cyc and wb_stb");
        violations++;
    end

    // a held strobe must not see two acks in a row
    ack_single_cycle: assert property (
        @(posedge clk) disable iff (!arst_n)
        (wb_ack && wb_stb) |=> !(wb_ack && wb_stb)
    ) else begin
        $error("wb_ack stayed high for two cycles under one strobe");
        violations++;
    end

    // read data must be fully defined while it is valid
    read_data_known: assert property (
        @(posedge clk) disable iff (!arst_n)
        wb_ack |-> !$isunknown(wb_dat_r)
    ) else begin
        $error("wb_dat_r has unknown bits during ack");
        violations++;
    end

endmodule

bind alu_regs alu_unit_asserts asserts_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_ack   (wb_ack),
    .wb_dat_r (wb_dat_r)
);

/* dv/alu_unit_tb.sv */
`timescale 1ns/1ps

`include "alu_settings.svh"

module alu_unit_tb;

    import alu_pkg::*;

    localparam int clk_period   = 100;
    localparam int reset_cycles = 10;
    localparam int ack_limit    = 8;
    localparam int op_pairs     = 20;
    localparam int force_pairs  = 4;
    localparam int chain_pairs  = 8;

    // the watchdog is sized from the bus accesses of each test
    localparam int op_accesses     = 7;
    localparam int chain_accesses  = 11;
    localparam int total_accesses  = 6
                                   + 16 * op_pairs * op_accesses
                                   + (force_pairs * 2 + 32) * op_accesses + 4
                                   + chain_pairs * 2 * chain_accesses
                                   + 12 * op_accesses;
    // every access spans three clocks and reset and some slack come on top
    localparam int watchdog_cycles = reset_cycles + 3 * total_accesses + 200;

    // the sixteen defined opcodes
    localparam logic [4:0] legal_ops [16] = '{
        5'd0, 5'd1, 5'd2, 5'd3, 5'd4, 5'd5, 5'd6, 5'd7,
        5'd8, 5'd9, 5'd10, 5'd11, 5'd16, 5'd17, 5'd25, 5'd26
    };

    logic      clk;
    logic      arst_n;
    logic      wb_cyc;
    logic      wb_stb;
    logic      wb_we;
    alu_adr_t  wb_adr;
    alu_data_t wb_dat_w;
    alu_data_t wb_dat_r;
    logic      wb_ack;

    int pass_count = 0;
    int fail_count = 0;

    alu_unit_top alu_unit_top_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run hung", watchdog_cycles);
        $display("SOME TESTS FAILED");
        $finish;
    end

    // expected {illegal, zero_n, carry_out_n, result} from the opcode table
    function automatic logic [10:0] predict(input logic [7:0] xa, input logic [7:0] yb,
                                            input logic [4:0] opc, input logic pass_x,
                                            input logic zero_x, input logic cin_n);
        logic [7:0]  a;
        logic [4:0]  eop;
        logic [8:0]  a9;
        logic [8:0]  b9;
        logic [8:0]  c9;
        logic [8:0]  s9;
        logic [15:0] prod;
        logic [7:0]  res;
        logic        ill;
        a    = zero_x ? 8'h00 : xa;
        eop  = pass_x ? 5'd0 : opc;
        a9   = {1'b0, a};
        b9   = {1'b0, yb};
        c9   = {8'h00, ~cin_n};
        s9   = 9'd0;
        prod = {8'h00, a} * {8'h00, yb};
        ill  = 1'b0;
        res  = 8'h00;
        case (eop)
            5'd0:  res = a;
            5'd1:  res = yb;
            5'd2:  res = 8'h00;
            5'd3:  s9 = 9'd0 - a9;
            5'd4:  s9 = 9'd0 - b9;
            5'd5:  s9 = a9 + 9'd1;
            5'd6:  s9 = b9 + 9'd1;
            5'd7:  s9 = a9 - 9'd1;
            5'd8:  s9 = b9 - 9'd1;
            5'd9:  s9 = a9 + b9 + c9;
            5'd10: s9 = a9 - b9 - c9;
            5'd11: s9 = b9 - a9 - c9;
            5'd16: res = prod[15:8];
            5'd17: res = prod[7:0];
            5'd25: res = a & yb;
            5'd26: res = a | yb;
            default: ill = 1'b1;
        endcase
        // opcodes 3 to 11 take their byte from the 9-bit sum
        if (eop >= 5'd3 && eop <= 5'd11) begin
            res = s9[7:0];
        end
        return {ill, (res != 8'h00), ~s9[8], res};
    endfunction

    task automatic check(input string what, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            fail_count++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic wb_write(input logic [2:0] adr, input logic [7:0] data);
        int waited;
        waited = 0;
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_dat_w = data;
        do begin
            @(negedge clk);
            waited++;
        end while (!wb_ack && waited < ack_limit);
        if (!wb_ack) begin
            $display("bus write to register %0d was never acknowledged", adr);
            fail_count++;
        end
        // the write lands on the next rising edge and the strobe drops after it
        @(negedge clk);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_read(input logic [2:0] adr, output logic [7:0] data);
        int waited;
        waited = 0;
        @(negedge clk);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        do begin
            @(negedge clk);
            waited++;
        end while (!wb_ack && waited < ack_limit);
        if (wb_ack) begin
            data = wb_dat_r;
        end else begin
            $display("bus read of register %0d was never acknowledged", adr);
            fail_count++;
            data = 8'h00;
        end
        @(negedge clk);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    // one full operation through the register map is checked against the prediction
    task automatic run_op(input logic [7:0] xv, input logic [7:0] yv, input logic [4:0] opc,
                          input logic pass_x, input logic zero_x, input logic cin_n,
                          output logic [7:0] res_rd, output logic [7:0] flags_rd);
        logic [10:0] exp;
        string       tag;
        exp = predict(xv, yv, opc, pass_x, zero_x, cin_n);
        tag = $sformatf("op %0d x %h y %h cin_n %b px %b zx %b",
                        opc, xv, yv, cin_n, pass_x, zero_x);
        wb_write(`ALU_REG_X, xv);
        wb_write(`ALU_REG_Y, yv);
        wb_write(`ALU_REG_OP, {1'b0, zero_x, pass_x, opc});
        wb_write(`ALU_REG_FLAGS, {7'd0, cin_n});
        wb_write(`ALU_REG_CMD, 8'h5a);
        wb_read(`ALU_REG_RES, res_rd);
        check({tag, " res"}, {8'h00, res_rd}, {8'h00, exp[7:0]});
        wb_read(`ALU_REG_FLAGS, flags_rd);
        // the capture also copies carry_out_n into cin_n
        check({tag, " flags"}, {8'h00, flags_rd},
              {12'h000, exp[10], exp[9], exp[8], exp[8]});
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (fail_count == errors_before) begin
            $display("test %s: passed", name);
        end else begin
            $display("test %s: failed with %0d errors", name, fail_count - errors_before);
        end
    endtask

    task automatic read_reset_values();
        logic [7:0] rd;
        int         errors_before;
        errors_before = fail_count;
        wb_read(`ALU_REG_X, rd);
        check("reset x", {8'h00, rd}, 16'h0000);
        wb_read(`ALU_REG_Y, rd);
        check("reset y", {8'h00, rd}, 16'h0000);
        wb_read(`ALU_REG_OP, rd);
        check("reset op", {8'h00, rd}, 16'h0000);
        wb_read(`ALU_REG_CMD, rd);
        check("reset cmd", {8'h00, rd}, 16'h0000);
        wb_read(`ALU_REG_RES, rd);
        check("reset res", {8'h00, rd}, 16'h0000);
        // cin_n, carry_out_n and zero_n come out of reset high
        wb_read(`ALU_REG_FLAGS, rd);
        check("reset flags", {8'h00, rd}, 16'h0007);
        report_test("reset values", errors_before);
    endtask

    task automatic sweep_opcodes();
        logic [7:0] xv;
        logic [7:0] yv;
        logic       cv;
        logic [7:0] res;
        logic [7:0] fl;
        int         errors_before;
        errors_before = fail_count;
        for (int k = 0; k < 16; k++) begin
            for (int i = 0; i < op_pairs; i++) begin
                xv = 8'($urandom());
                yv = 8'($urandom());
                cv = 1'($urandom());
                run_op(xv, yv, legal_ops[k], 1'b0, 1'b0, cv, res, fl);
            end
        end
        report_test("all opcodes", errors_before);
    endtask

    task automatic apply_forcing();
        logic [7:0] xv;
        logic [7:0] yv;
        logic       cv;
        logic [7:0] res;
        logic [7:0] fl;
        logic [7:0] rd;
        int         errors_before;
        errors_before = fail_count;
        for (int i = 0; i < force_pairs; i++) begin
            xv = 8'($urandom());
            yv = 8'($urandom());
            cv = 1'($urandom());
            run_op(xv, yv, 5'd0, 1'b0, 1'b1, cv, res, fl);
            check("x forced to zero, pass x", {8'h00, res}, 16'h0000);
            run_op(xv, yv, 5'd9, 1'b0, 1'b1, cv, res, fl);
        end
        // the last write left x forced to zero with op_a_plus_b
        wb_read(`ALU_REG_OP, rd);
        check("op readback with x forced to zero", {8'h00, rd}, 16'h0049);
        // pass-x wins over every opcode whether defined or not
        for (int opi = 0; opi < 32; opi++) begin
            xv = 8'($urandom());
            yv = 8'($urandom());
            cv = 1'($urandom());
            run_op(xv, yv, 5'(opi), 1'b1, 1'b0, cv, res, fl);
            check($sformatf("forced pass x on op %0d", opi), {8'h00, res}, {8'h00, xv});
        end
        // the registers still hold the operands and the opcode of the last pass-x run
        wb_read(`ALU_REG_X, rd);
        check("x readback", {8'h00, rd}, {8'h00, xv});
        wb_read(`ALU_REG_Y, rd);
        check("y readback", {8'h00, rd}, {8'h00, yv});
        wb_read(`ALU_REG_OP, rd);
        check("op readback with pass x", {8'h00, rd}, 16'h003f);
        report_test("forcing", errors_before);
    endtask

    task automatic chain_op(input logic [15:0] a, input logic [15:0] b, input logic sub);
        logic [16:0] wide;
        logic [7:0]  lo;
        logic [7:0]  hi;
        logic [7:0]  fl;
        wide = sub ? {1'b0, a} - {1'b0, b} : {1'b0, a} + {1'b0, b};
        wb_write(`ALU_REG_FLAGS, 8'h01);
        wb_write(`ALU_REG_OP, sub ? 8'd10 : 8'd9);
        wb_write(`ALU_REG_X, a[7:0]);
        wb_write(`ALU_REG_Y, b[7:0]);
        wb_write(`ALU_REG_CMD, 8'h00);
        wb_read(`ALU_REG_RES, lo);
        // the high byte runs on the carry captured from the low byte
        wb_write(`ALU_REG_X, a[15:8]);
        wb_write(`ALU_REG_Y, b[15:8]);
        wb_write(`ALU_REG_CMD, 8'h00);
        wb_read(`ALU_REG_RES, hi);
        wb_read(`ALU_REG_FLAGS, fl);
        check($sformatf("chain %s %h %h", sub ? "sub" : "add", a, b), {hi, lo}, wide[15:0]);
        check($sformatf("chain carry %h %h", a, b), {15'd0, fl[1]}, {15'd0, ~wide[16]});
    endtask

    task automatic wide_arithmetic();
        logic [15:0] a;
        logic [15:0] b;
        int          errors_before;
        errors_before = fail_count;
        for (int i = 0; i < chain_pairs; i++) begin
            a = 16'($urandom());
            b = 16'($urandom());
            chain_op(a, b, 1'b0);
            chain_op(a, b, 1'b1);
        end
        report_test("carry chain", errors_before);
    endtask

    task automatic provoke_illegal_and_zero();
        logic [4:0] bad_ops [3];
        logic [7:0] res;
        logic [7:0] fl;
        int         errors_before;
        errors_before = fail_count;
        bad_ops = '{5'd12, 5'd20, 5'd31};
        for (int k = 0; k < 3; k++) begin
            for (int i = 0; i < 2; i++) begin
                run_op(8'($urandom()), 8'($urandom()), bad_ops[k], 1'b0, 1'b0,
                       1'($urandom()), res, fl);
                check($sformatf("illegal op %0d res", bad_ops[k]), {8'h00, res}, 16'h0000);
                // illegal is set with zero_n low and carry_out_n high
                check($sformatf("illegal op %0d flags", bad_ops[k]),
                      {13'd0, fl[3:1]}, 16'h0005);
            end
        end
        run_op(8'h37, 8'h91, 5'd2, 1'b0, 1'b0, 1'b1, res, fl);
        check("zero op zero_n", {15'd0, fl[2]}, 16'h0000);
        run_op(8'h0f, 8'hf0, 5'd25, 1'b0, 1'b0, 1'b1, res, fl);
        check("and to zero zero_n", {15'd0, fl[2]}, 16'h0000);
        run_op(8'h42, 8'h42, 5'd10, 1'b0, 1'b0, 1'b1, res, fl);
        check("equal subtract zero_n", {15'd0, fl[2]}, 16'h0000);
        run_op(8'hff, 8'h00, 5'd5, 1'b0, 1'b0, 1'b1, res, fl);
        check("increment wrap zero_n", {15'd0, fl[2]}, 16'h0000);
        run_op(8'h10, 8'h10, 5'd17, 1'b0, 1'b0, 1'b1, res, fl);
        check("multiply low zero_n", {15'd0, fl[2]}, 16'h0000);
        run_op(8'h00, 8'h01, 5'd8, 1'b0, 1'b0, 1'b1, res, fl);
        check("y decrement zero_n", {15'd0, fl[2]}, 16'h0000);
        report_test("illegal and zero", errors_before);
    endtask

    initial begin
        void'($urandom(32'h14d847f6));
        arst_n   = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        read_reset_values();
        sweep_opcodes();
        apply_forcing();
        wide_arithmetic();
        provoke_illegal_and_zero();

        if (alu_unit_top_i.regs_i.asserts_i.violations != 0) begin
            $display("bus protocol assertions failed %0d times",
                     alu_unit_top_i.regs_i.asserts_i.violations);
            fail_count++;
        end

        $display("summary: %0d checks passed, %0d checks failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* flist.f */
+incdir+source
source/alu_pkg.sv
source/alu_core.sv
source/alu_regs.sv
source/alu_unit_top.sv
dv/alu_unit_asserts.sv
dv/alu_unit_tb.sv

/* source/alu_core.sv */
`timescale 1ns/1ps

`include "alu_settings.svh"

module alu_core (
    input  alu_pkg::alu_data_t   x,
    input  alu_pkg::alu_data_t   y,
    input  logic [`ALU_OP_W-1:0] op,
    input  logic                 force_pass_x,
    input  logic                 force_x_zero,
    input  logic                 cin_n,
    output alu_pkg::alu_data_t   result,
    output logic                 carry_out_n,
    output logic                 zero_n,
    output logic                 illegal
);

    import alu_pkg::*;

    alu_data_t               x_eff;
    alu_op_e                 op_eff;
    logic [`ALU_DATA_W:0]    x9;
    logic [`ALU_DATA_W:0]    y9;
    logic [`ALU_DATA_W:0]    cin9;
    logic [`ALU_DATA_W:0]    sum9;
    logic [2*`ALU_DATA_W-1:0] product;

    // the two forcing controls replace the bus transceivers of the CPU
    // x forced to zero also applies under pass-x
    assign x_eff  = force_x_zero ? '0 : x;
    assign op_eff = force_pass_x ? op_a : alu_op_e'(op);

    // all carry arithmetic is done one bit wider than the data
    assign x9   = {1'b0, x_eff};
    assign y9   = {1'b0, y};

    // carry-in is active low on the flag register
    assign cin9 = {{`ALU_DATA_W{1'b0}}, ~cin_n};

    assign product = {{`ALU_DATA_W{1'b0}}, x_eff} * {{`ALU_DATA_W{1'b0}}, y};

    always_comb begin
        result  = '0;
        sum9    = '0;
        illegal = 1'b0;
        case (op_eff)
            op_a: begin
                result = x_eff;
            end
            op_b: begin
                result = y;
            end
            op_zero: begin
                result = '0;
            end
            op_neg_a: begin
                sum9   = -x9;
                result = sum9[`ALU_DATA_W-1:0];
            end
            op_neg_b: begin
                sum9   = -y9;
                result = sum9[`ALU_DATA_W-1:0];
            end
            op_a_inc: begin
                sum9   = x9 + (`ALU_DATA_W+1)'(1);
                result = sum9[`ALU_DATA_W-1:0];
            end
            op_b_inc: begin
                sum9   = y9 + (`ALU_DATA_W+1)'(1);
                result = sum9[`ALU_DATA_W-1:0];
            end
            op_a_dec: begin
                sum9   = x9 - (`ALU_DATA_W+1)'(1);
                result = sum9[`ALU_DATA_W-1:0];
            end
            op_b_dec: begin
                sum9   = y9 - (`ALU_DATA_W+1)'(1);
                result = sum9[`ALU_DATA_W-1:0];
            end
            op_a_plus_b: begin
                sum9   = x9 + y9 + cin9;
                result = sum9[`ALU_DATA_W-1:0];
            end
            op_a_minus_b: begin
                // a borrow shows up in bit 8 and chains like an add carry
                sum9   = x9 - y9 - cin9;
                result = sum9[`ALU_DATA_W-1:0];
            end
            op_b_minus_a: begin
                sum9   = y9 - x9 - cin9;
                result = sum9[`ALU_DATA_W-1:0];
            end
            op_mul_hi: begin
                result = product[2*`ALU_DATA_W-1:`ALU_DATA_W];
            end
            op_mul_lo: begin
                result = product[`ALU_DATA_W-1:0];
            end
            op_and: begin
                result = x_eff & y;
            end
            op_or: begin
                result = x_eff | y;
            end
            default: begin
                // an undefined opcode keeps the result at 0 and raises the flag
                illegal = 1'b1;
            end
        endcase
    end

    // non-arithmetic opcodes leave sum9 at 0 and report no carry
    assign carry_out_n = ~sum9[`ALU_DATA_W];

    // zero_n is high while the result has any bit set
    assign zero_n = (result != '0);

endmodule

/* source/alu_pkg.sv */
`include "alu_settings.svh"

package alu_pkg;

    // one operand or result byte
    typedef logic [`ALU_DATA_W-1:0] alu_data_t;

    // wishbone word address
    typedef logic [`ALU_ADR_W-1:0] alu_adr_t;

    // supported opcodes, numbered as on the CPU control word
    // gaps in the numbering are undefined and flagged as illegal by the core
    typedef enum logic [`ALU_OP_W-1:0] {
        op_a         = 5'd0,
        op_b         = 5'd1,
        op_zero      = 5'd2,
        op_neg_a     = 5'd3,
        op_neg_b     = 5'd4,
        op_a_inc     = 5'd5,
        op_b_inc     = 5'd6,
        op_a_dec     = 5'd7,
        op_b_dec     = 5'd8,
        // the three carry-in opcodes below use the active-low cin_n
        op_a_plus_b  = 5'd9,
        op_a_minus_b = 5'd10,
        op_b_minus_a = 5'd11,
        // multiply gives a 16-bit product, one byte per opcode
        op_mul_hi    = 5'd16,
        op_mul_lo    = 5'd17,
        op_and       = 5'd25,
        op_or        = 5'd26
    } alu_op_e;

endpackage

/* source/alu_regs.sv */
`timescale 1ns/1ps

`include "alu_settings.svh"

module alu_regs (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_we,
    input  alu_pkg::alu_adr_t    wb_adr,
    input  alu_pkg::alu_data_t   wb_dat_w,
    output alu_pkg::alu_data_t   wb_dat_r,
    output logic                 wb_ack,
    output alu_pkg::alu_data_t   x,
    output alu_pkg::alu_data_t   y,
    output logic [`ALU_OP_W-1:0] op,
    output logic                 force_pass_x,
    output logic                 force_x_zero,
    output logic                 cin_n,
    input  alu_pkg::alu_data_t   result,
    input  logic                 carry_out_n,
    input  logic                 zero_n,
    input  logic                 illegal
);

    import alu_pkg::*;

    alu_data_t res_q;
    logic      carry_out_n_q;
    logic      zero_n_q;
    logic      illegal_q;
    logic      wr_en;

    // ack follows the first sampled strobe by one clock and lasts one cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= wb_cyc & wb_stb & ~wb_ack;
        end
    end

    // writes land on the ack edge
    assign wr_en = wb_cyc & wb_stb & wb_we & wb_ack;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            x             <= '0;
            y             <= '0;
            op            <= '0;
            force_pass_x  <= 1'b0;
            force_x_zero  <= 1'b0;
            cin_n         <= 1'b1;
            res_q         <= '0;
            carry_out_n_q <= 1'b1;
            zero_n_q      <= 1'b1;
            illegal_q     <= 1'b0;
        end else if (wr_en) begin
            case (wb_adr)
                `ALU_REG_X: x <= wb_dat_w;
                `ALU_REG_Y: y <= wb_dat_w;
                `ALU_REG_OP: begin
                    op           <= wb_dat_w[`ALU_OP_W-1:0];
                    force_pass_x <= wb_dat_w[5];
                    force_x_zero <= wb_dat_w[6];
                end
                `ALU_REG_CMD: begin
                    // snapshot of the core, carry is fed back for the next byte
                    res_q         <= result;
                    carry_out_n_q <= carry_out_n;
                    zero_n_q      <= zero_n;
                    illegal_q     <= illegal;
                    cin_n         <= carry_out_n;
                end
                `ALU_REG_FLAGS: cin_n <= wb_dat_w[0];
                default: ;
            endcase
        end
    end

    // read data is only driven during the ack cycle
    always_comb begin
        wb_dat_r = '0;
        if (wb_ack) begin
            case (wb_adr)
                `ALU_REG_X:     wb_dat_r = x;
                `ALU_REG_Y:     wb_dat_r = y;
                `ALU_REG_OP:    wb_dat_r = alu_data_t'({force_x_zero, force_pass_x, op});
                `ALU_REG_RES:   wb_dat_r = res_q;
                `ALU_REG_FLAGS: begin
                    wb_dat_r = alu_data_t'({illegal_q, zero_n_q, carry_out_n_q, cin_n});
                end
                default:        wb_dat_r = '0;
            endcase
        end
    end

endmodule

/* source/alu_settings.svh */
`ifndef ALU_SETTINGS_SVH
`define ALU_SETTINGS_SVH

// operand and result width, the core is a byte-wide ALU
`define ALU_DATA_W 8

// opcode field width, the top opcode is 31
`define ALU_OP_W 5

// wishbone word address width, six registers used out of eight
`define ALU_ADR_W 3

// register offsets on the wishbone word address
`define ALU_REG_X     3'd0
`define ALU_REG_Y     3'd1
`define ALU_REG_OP    3'd2
`define ALU_REG_CMD   3'd3
`define ALU_REG_RES   3'd4
`define ALU_REG_FLAGS 3'd5

`endif

/* source/alu_unit_top.sv */
`timescale 1ns/1ps

`include "alu_settings.svh"

module alu_unit_top (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               wb_cyc,
    input  logic               wb_stb,
    input  logic               wb_we,
    input  alu_pkg::alu_adr_t  wb_adr,
    input  alu_pkg::alu_data_t wb_dat_w,
    output alu_pkg::alu_data_t wb_dat_r,
    output logic               wb_ack
);

    import alu_pkg::*;

    // register fields steering the core
    alu_data_t            x;
    alu_data_t            y;
    logic [`ALU_OP_W-1:0] op;
    logic                 force_pass_x;
    logic                 force_x_zero;
    logic                 cin_n;

    // combinational core outputs, captured on a CMD write
    alu_data_t            result;
    logic                 carry_out_n;
    logic                 zero_n;
    logic                 illegal;

    alu_regs regs_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .wb_dat_r     (wb_dat_r),
        .wb_ack       (wb_ack),
        .x            (x),
        .y            (y),
        .op           (op),
        .force_pass_x (force_pass_x),
        .force_x_zero (force_x_zero),
        .cin_n        (cin_n),
        .result       (result),
        .carry_out_n  (carry_out_n),
        .zero_n       (zero_n),
        .illegal      (illegal)
    );

    alu_core core_i (
        .x            (x),
        .y            (y),
        .op           (op),
        .force_pass_x (force_pass_x),
        .force_x_zero (force_x_zero),
        .cin_n        (cin_n),
        .result       (result),
        .carry_out_n  (carry_out_n),
        .zero_n       (zero_n),
        .illegal      (illegal)
    );

endmodule
